/* power_pkg.sv */
package power_pkg;

    ////////////////////////////////////////
    // cluster sizing
    ////////////////////////////////////////

    localparam int NUM_CORES     = 4;
    localparam int CORE_IDX_W    = $clog2(NUM_CORES);

    ////////////////////////////////////////
    // timing and thresholds
    ////////////////////////////////////////

    localparam int STATE_TIMER_W  = 16;
    localparam int IDLE_TIMEOUT   = 16;   // quiet cycles before ACTIVE -> IDLE
    localparam int IDLE_CNT_W     = $clog2(IDLE_TIMEOUT + 1);
    localparam int BUSY_HOLD      = 4;    // cycles a core stays active after busy
    localparam int HOLD_W         = $clog2(BUSY_HOLD + 1);
    localparam int MISS_WINDOW    = 64;
    localparam int WINDOW_W       = $clog2(MISS_WINDOW);
    localparam int MISS_RATE_W    = 8;
    localparam int MISS_THRESHOLD = 10;   // L3 stays clocked above this

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        POWER_ACTIVE           = 3'd0,
        POWER_IDLE             = 3'd1,
        POWER_SLEEP            = 3'd2,
        POWER_DEEP_SLEEP       = 3'd3,
        POWER_THERMAL_THROTTLE = 3'd4
    } power_state_t;

    // static configuration driven from plain pins at the top
    typedef struct packed {
        logic aggressive_gating;
        logic cache_gating_en;
        logic retention_mode;   // keep L2 clocked in SLEEP
    } power_config_t;

endpackage

/* power_state_fsm.sv */
`timescale 1ns/1ps

module power_state_fsm
    import power_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     req_valid_i,
    input  power_state_t             req_state_i,
    input  logic                     thermal_alert_i,
    input  logic [NUM_CORES-1:0]     core_active_i,
    output logic                     req_ready_o,
    output power_state_t             power_state_o,
    output logic [STATE_TIMER_W-1:0] state_timer_o
);

    power_state_t             state_q;
    power_state_t             state_d;
    logic [IDLE_CNT_W-1:0]    idle_cnt_q;
    logic [IDLE_CNT_W-1:0]    idle_cnt_d;
    logic [STATE_TIMER_W-1:0] timer_q;
    logic                     any_active;
    logic                     req_fire;
    logic                     idle_timeout;
    logic                     state_change;

    assign any_active   = |core_active_i;
    assign req_ready_o  = (state_q != POWER_THERMAL_THROTTLE) && !thermal_alert_i;
    assign req_fire     = req_valid_i && req_ready_o;
    assign state_change = (state_d != state_q);

    // quiet cycles seen so far including this one
    always_comb begin
        if (any_active || state_q != POWER_ACTIVE) begin
            idle_cnt_d = '0;
        end else if (idle_cnt_q != IDLE_CNT_W'(IDLE_TIMEOUT)) begin
            idle_cnt_d = idle_cnt_q + 1'b1;
        end else begin
            idle_cnt_d = idle_cnt_q;   // saturate
        end
    end

    assign idle_timeout = (idle_cnt_d == IDLE_CNT_W'(IDLE_TIMEOUT));

    ////////////////////////////////////////
    // next state, highest priority first
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        if (thermal_alert_i && (state_q == POWER_ACTIVE || state_q == POWER_IDLE)) begin
            state_d = POWER_THERMAL_THROTTLE;
        end else if (state_q == POWER_THERMAL_THROTTLE) begin
            if (!thermal_alert_i) begin
                state_d = POWER_ACTIVE;   // alert cleared
            end
        end else if (req_fire) begin
            case (req_state_i)
                POWER_SLEEP, POWER_DEEP_SLEEP: state_d = req_state_i;
                default:                       state_d = POWER_ACTIVE;
            endcase
        end else if (state_q == POWER_ACTIVE && idle_timeout) begin
            state_d = POWER_IDLE;
        end else if (state_q == POWER_IDLE && any_active) begin
            state_d = POWER_ACTIVE;
        end
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= POWER_ACTIVE;
            idle_cnt_q <= '0;
            timer_q    <= '0;
        end else begin
            state_q <= state_d;
            if (state_change) begin
                idle_cnt_q <= '0;
                timer_q    <= '0;
            end else begin
                idle_cnt_q <= idle_cnt_d;
                if (timer_q != '1) begin
                    timer_q <= timer_q + 1'b1;   // saturating
                end
            end
        end
    end

    assign power_state_o = state_q;
    assign state_timer_o = timer_q;

    a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q inside {POWER_ACTIVE, POWER_IDLE, POWER_SLEEP, POWER_DEEP_SLEEP,
                        POWER_THERMAL_THROTTLE})
        else $error("illegal power state encoding %0h", state_q);

endmodule

/* activity_monitor.sv */
`timescale 1ns/1ps

module activity_monitor
    import power_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [NUM_CORES-1:0]   core_busy_i,
    input  logic                   cache_access_i,
    input  logic                   cache_miss_i,
    output logic [NUM_CORES-1:0]   core_active_o,
    output logic                   cache_active_o,
    output logic [MISS_RATE_W-1:0] miss_rate_o
);

    logic [HOLD_W-1:0]      hold_q [NUM_CORES];
    logic [WINDOW_W-1:0]    win_cnt_q;
    logic [MISS_RATE_W-1:0] miss_cnt_q;
    logic [MISS_RATE_W-1:0] miss_cnt_next;
    logic [MISS_RATE_W-1:0] miss_rate_q;
    logic                   acc_cur_q;    // access seen in this window
    logic                   acc_prev_q;   // access seen in the last window
    logic                   win_end;

    ////////////////////////////////////////
    // busy hold per core
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (core_busy_i[i]) begin
                    hold_q[i] <= HOLD_W'(BUSY_HOLD);
                end else if (hold_q[i] != '0) begin
                    hold_q[i] <= hold_q[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_active_o[i] = (hold_q[i] != '0);
        end
    end

    ////////////////////////////////////////
    // cache window
    ////////////////////////////////////////

    assign win_end       = (win_cnt_q == WINDOW_W'(MISS_WINDOW - 1));
    assign miss_cnt_next = (cache_miss_i && miss_cnt_q != '1) ? miss_cnt_q + 1'b1 : miss_cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            win_cnt_q   <= '0;
            miss_cnt_q  <= '0;
            miss_rate_q <= '0;
            acc_cur_q   <= 1'b0;
            acc_prev_q  <= 1'b0;
        end else begin
            win_cnt_q <= win_end ? '0 : win_cnt_q + 1'b1;
            if (win_end) begin
                miss_rate_q <= miss_cnt_next;   // count of the window just ended
                miss_cnt_q  <= '0;
                acc_prev_q  <= acc_cur_q | cache_access_i;
                acc_cur_q   <= 1'b0;
            end else begin
                miss_cnt_q <= miss_cnt_next;
                acc_cur_q  <= acc_cur_q | cache_access_i;
            end
        end
    end

    assign cache_active_o = acc_cur_q | acc_prev_q;
    assign miss_rate_o    = miss_rate_q;

    a_window_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        int'(win_cnt_q) < MISS_WINDOW)
        else $error("window counter out of range %0d", win_cnt_q);

endmodule

/* clock_gating_control.sv */
`timescale 1ns/1ps

module clock_gating_control
    import power_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  power_state_t             current_power_state_i,
    input  power_config_t            power_config_i,
    input  logic [NUM_CORES-1:0]     core_active_i,
    input  logic                     cache_active_i,
    input  logic [MISS_RATE_W-1:0]   cache_miss_rate_i,
    input  logic [STATE_TIMER_W-1:0] state_timer_i,
    output logic [NUM_CORES-1:0]     core_clk_en_o,
    output logic                     l2_cache_clk_en_o,
    output logic                     l3_cache_clk_en_o,
    output logic                     interconnect_clk_en_o
);

    logic [NUM_CORES-1:0] core_en_q;
    logic                 l2_en_q;
    logic                 l3_en_q;
    logic                 ic_en_q;
    logic                 miss_high;
    logic [CORE_IDX_W-1:0] throttle_sel;   // core allowed to run while throttled

    assign miss_high    = (cache_miss_rate_i > MISS_RATE_W'(MISS_THRESHOLD));
    assign throttle_sel = state_timer_i[CORE_IDX_W-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            core_en_q <= '1;   // clocks run out of reset
            l2_en_q   <= 1'b1;
            l3_en_q   <= 1'b1;
            ic_en_q   <= 1'b1;
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                case (current_power_state_i)
                    POWER_ACTIVE: begin
                        core_en_q[i] <= core_active_i[i] || !power_config_i.aggressive_gating;
                    end
                    POWER_IDLE: begin
                        core_en_q[i] <= core_active_i[i];
                    end
                    POWER_SLEEP, POWER_DEEP_SLEEP: begin
                        core_en_q[i] <= 1'b0;
                    end
                    POWER_THERMAL_THROTTLE: begin
                        core_en_q[i] <= (throttle_sel == CORE_IDX_W'(i)) && core_active_i[i];
                    end
                    default: begin
                        core_en_q[i] <= core_active_i[i];
                    end
                endcase
            end

            case (current_power_state_i)
                POWER_ACTIVE, POWER_IDLE: begin
                    l2_en_q <= cache_active_i || !power_config_i.cache_gating_en;
                    l3_en_q <= miss_high || !power_config_i.cache_gating_en;
                end
                POWER_SLEEP: begin
                    l2_en_q <= power_config_i.retention_mode;
                    l3_en_q <= 1'b0;
                end
                POWER_DEEP_SLEEP: begin
                    l2_en_q <= 1'b0;
                    l3_en_q <= 1'b0;
                end
                default: begin   // throttle
                    l2_en_q <= cache_active_i;
                    l3_en_q <= cache_active_i;
                end
            endcase

            ic_en_q <= (current_power_state_i == POWER_ACTIVE) ||
                       (current_power_state_i == POWER_IDLE && |core_active_i);
        end
    end

    assign core_clk_en_o         = core_en_q;
    assign l2_cache_clk_en_o     = l2_en_q;
    assign l3_cache_clk_en_o     = l3_en_q;
    assign interconnect_clk_en_o = ic_en_q;

    // deep sleep must shut every clock on the following edge
    a_deep_sleep_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        current_power_state_i == POWER_DEEP_SLEEP |=>
            (core_clk_en_o == '0) && !l2_cache_clk_en_o && !l3_cache_clk_en_o &&
            !interconnect_clk_en_o)
        else $error("clock enable left on in deep sleep");

endmodule

/* power_mgmt_top.sv */
`timescale 1ns/1ps

module power_mgmt_top
    import power_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [NUM_CORES-1:0] core_busy_i,
    input  logic                 cache_access_i,
    input  logic                 cache_miss_i,
    input  logic                 thermal_alert_i,
    input  logic                 req_valid_i,
    input  power_state_t         req_state_i,
    input  logic                 cfg_aggressive_gating_i,
    input  logic                 cfg_cache_gating_en_i,
    input  logic                 cfg_retention_mode_i,
    output logic                 req_ready_o,
    output power_state_t         power_state_o,
    output logic [NUM_CORES-1:0] core_clk_en_o,
    output logic                 l2_cache_clk_en_o,
    output logic                 l3_cache_clk_en_o,
    output logic                 interconnect_clk_en_o
);

    logic [NUM_CORES-1:0]     core_active;
    logic                     cache_active;
    logic [MISS_RATE_W-1:0]   miss_rate;
    power_state_t             power_state;
    logic [STATE_TIMER_W-1:0] state_timer;
    power_config_t            power_cfg;

    assign power_cfg = '{
        aggressive_gating: cfg_aggressive_gating_i,
        cache_gating_en:   cfg_cache_gating_en_i,
        retention_mode:    cfg_retention_mode_i
    };

    activity_monitor i_activity_monitor (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .core_busy_i    (core_busy_i),
        .cache_access_i (cache_access_i),
        .cache_miss_i   (cache_miss_i),
        .core_active_o  (core_active),
        .cache_active_o (cache_active),
        .miss_rate_o    (miss_rate)
    );

    power_state_fsm i_power_state_fsm (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_state_i     (req_state_i),
        .thermal_alert_i (thermal_alert_i),
        .core_active_i   (core_active),
        .req_ready_o     (req_ready_o),
        .power_state_o   (power_state),
        .state_timer_o   (state_timer)
    );

    clock_gating_control i_clock_gating_control (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .current_power_state_i (power_state),
        .power_config_i        (power_cfg),
        .core_active_i         (core_active),
        .cache_active_i        (cache_active),
        .cache_miss_rate_i     (miss_rate),
        .state_timer_i         (state_timer),
        .core_clk_en_o         (core_clk_en_o),
        .l2_cache_clk_en_o     (l2_cache_clk_en_o),
        .l3_cache_clk_en_o     (l3_cache_clk_en_o),
        .interconnect_clk_en_o (interconnect_clk_en_o)
    );

    assign power_state_o = power_state;

endmodule

/* power_mgmt_tb.sv */
`timescale 1ns/1ps

module power_mgmt_tb import power_pkg::*; ();

    localparam int CLK_HALF       = 50;
    localparam int DRIVE_DELAY    = 5;
    localparam int RESET_CYCLES   = 8;
    localparam int RUN_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
    localparam int CFG_PERIOD     = 200;   // config bits and load mode change here
    localparam int TIMER_MAX      = (1 << STATE_TIMER_W) - 1;
    localparam int MISS_MAX       = (1 << MISS_RATE_W) - 1;

    logic                 clk_i;
    logic                 rst_ni;
    logic [NUM_CORES-1:0] core_busy_i;
    logic                 cache_access_i;
    logic                 cache_miss_i;
    logic                 thermal_alert_i;
    logic                 req_valid_i;
    power_state_t         req_state_i;
    logic                 cfg_aggressive_gating_i;
    logic                 cfg_cache_gating_en_i;
    logic                 cfg_retention_mode_i;
    logic                 req_ready_o;
    power_state_t         power_state_o;
    logic [NUM_CORES-1:0] core_clk_en_o;
    logic                 l2_cache_clk_en_o;
    logic                 l3_cache_clk_en_o;
    logic                 interconnect_clk_en_o;

    power_mgmt_top dut0 (.*);

    always begin
        #(CLK_HALF) clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    logic [15:0] lfsr_q;
    int          alert_left;   // remaining cycles of a thermal burst

    function automatic logic take_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_bits(input int nbits);
        logic [7:0] val;
        val = '0;
        for (int k = 0; k < nbits; k++) begin
            val = {val[6:0], take_bit()};
        end
        return val;
    endfunction

    // true with odds of one in 2**nbits
    function automatic logic rand_chance(input int nbits);
        logic hit;
        hit = 1'b1;
        for (int k = 0; k < nbits; k++) begin
            if (take_bit()) begin
                hit = 1'b0;
            end
        end
        return hit;
    endfunction

    function automatic power_state_t pick_state();
        int sel;
        sel = int'(rand_bits(3)) % 5;
        return power_state_t'(sel[2:0]);
    endfunction

    ////////////////////////////////////////
    // cycle model
    ////////////////////////////////////////

    power_state_t         m_state;
    int                   m_quiet;
    int                   m_timer;
    int                   m_hold [NUM_CORES];
    int                   m_win;
    int                   m_miss_cnt;
    int                   m_miss_rate;
    logic                 m_acc_cur;
    logic                 m_acc_prev;
    logic [NUM_CORES-1:0] m_core_en;
    logic                 m_l2;
    logic                 m_l3;
    logic                 m_ic;
    logic                 m_req_fired;
    logic [7:0]           saw_state;
    logic                 saw_blocked;   // a request waited on back-pressure

    task automatic model_reset();
        m_state     = POWER_ACTIVE;
        m_quiet     = 0;
        m_timer     = 0;
        m_win       = 0;
        m_miss_cnt  = 0;
        m_miss_rate = 0;
        m_acc_cur   = 1'b0;
        m_acc_prev  = 1'b0;
        m_core_en   = '1;
        m_l2        = 1'b1;
        m_l3        = 1'b1;
        m_ic        = 1'b1;
        m_req_fired = 1'b0;
        saw_state   = '0;
        saw_blocked = 1'b0;
        for (int i = 0; i < NUM_CORES; i++) begin
            m_hold[i] = 0;
        end
    endtask

    function automatic logic model_ready();
        return (m_state != POWER_THERMAL_THROTTLE) && !thermal_alert_i;
    endfunction

    // advance the model by one clock with the inputs held across the edge
    task automatic model_step();
        logic [NUM_CORES-1:0] act;
        logic                 any_act;
        logic                 cache_act;
        logic                 fire;
        logic                 win_end;
        int                   quiet_next;
        int                   miss_next;
        power_state_t         next_state;

        for (int i = 0; i < NUM_CORES; i++) begin
            act[i] = (m_hold[i] != 0);
        end
        any_act   = |act;
        cache_act = m_acc_cur | m_acc_prev;
        fire      = req_valid_i && model_ready();
        if (req_valid_i && !model_ready()) begin
            saw_blocked = 1'b1;
        end

        // registered enables see this cycle's state and activity
        for (int i = 0; i < NUM_CORES; i++) begin
            case (m_state)
                POWER_ACTIVE:           m_core_en[i] = act[i] || !cfg_aggressive_gating_i;
                POWER_IDLE:             m_core_en[i] = act[i];
                POWER_THERMAL_THROTTLE: m_core_en[i] = act[i] && (m_timer % NUM_CORES == i);
                default:                m_core_en[i] = 1'b0;
            endcase
        end
        case (m_state)
            POWER_ACTIVE, POWER_IDLE: begin
                m_l2 = cache_act || !cfg_cache_gating_en_i;
                m_l3 = (m_miss_rate > MISS_THRESHOLD) || !cfg_cache_gating_en_i;
            end
            POWER_SLEEP: begin
                m_l2 = cfg_retention_mode_i;
                m_l3 = 1'b0;
            end
            POWER_THERMAL_THROTTLE: begin
                m_l2 = cache_act;
                m_l3 = cache_act;
            end
            default: begin
                m_l2 = 1'b0;
                m_l3 = 1'b0;
            end
        endcase
        m_ic = (m_state == POWER_ACTIVE) || (m_state == POWER_IDLE && any_act);

        // power state in priority order
        quiet_next = (m_state == POWER_ACTIVE && !any_act) ? m_quiet + 1 : 0;
        next_state = m_state;
        if (thermal_alert_i && (m_state == POWER_ACTIVE || m_state == POWER_IDLE)) begin
            next_state = POWER_THERMAL_THROTTLE;
        end else if (m_state == POWER_THERMAL_THROTTLE) begin
            if (!thermal_alert_i) begin
                next_state = POWER_ACTIVE;
            end
        end else if (fire) begin
            if (req_state_i == POWER_SLEEP || req_state_i == POWER_DEEP_SLEEP) begin
                next_state = req_state_i;
            end else begin
                next_state = POWER_ACTIVE;
            end
        end else if (m_state == POWER_ACTIVE && quiet_next >= IDLE_TIMEOUT) begin
            next_state = POWER_IDLE;
        end else if (m_state == POWER_IDLE && any_act) begin
            next_state = POWER_ACTIVE;
        end
        if (next_state != m_state) begin
            m_quiet = 0;
            m_timer = 0;
        end else begin
            m_quiet = (quiet_next > IDLE_TIMEOUT) ? IDLE_TIMEOUT : quiet_next;
            m_timer = (m_timer < TIMER_MAX) ? m_timer + 1 : m_timer;
        end
        m_state                 = next_state;
        m_req_fired             = fire;
        saw_state[int'(m_state)] = 1'b1;

        // activity monitor
        for (int i = 0; i < NUM_CORES; i++) begin
            if (core_busy_i[i]) begin
                m_hold[i] = BUSY_HOLD;
            end else if (m_hold[i] > 0) begin
                m_hold[i] = m_hold[i] - 1;
            end
        end
        win_end   = (m_win == MISS_WINDOW - 1);
        miss_next = (cache_miss_i && m_miss_cnt < MISS_MAX) ? m_miss_cnt + 1 : m_miss_cnt;
        if (win_end) begin
            m_miss_rate = miss_next;
            m_miss_cnt  = 0;
            m_acc_prev  = m_acc_cur | cache_access_i;
            m_acc_cur   = 1'b0;
            m_win       = 0;
        end else begin
            m_miss_cnt = miss_next;
            m_acc_cur  = m_acc_cur | cache_access_i;
            m_win      = m_win + 1;
        end
    endtask

    ////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////

    task automatic drive_inputs(input int cyc);
        int mode;
        mode = (cyc / CFG_PERIOD) % 4;   // 0 quiet, 1 light load, else heavy load
        if (cyc % CFG_PERIOD == 0) begin
            cfg_aggressive_gating_i = take_bit();
            cfg_cache_gating_en_i   = take_bit();
            cfg_retention_mode_i    = take_bit();
        end
        for (int i = 0; i < NUM_CORES; i++) begin
            case (mode)
                0:       core_busy_i[i] = 1'b0;
                1:       core_busy_i[i] = rand_chance(4);
                default: core_busy_i[i] = rand_chance(2);
            endcase
        end
        cache_access_i = rand_chance(6);
        cache_miss_i   = rand_chance((mode % 2 == 1) ? 3 : 2);
        if (alert_left > 0) begin
            thermal_alert_i = 1'b1;
            alert_left      = alert_left - 1;
        end else if (rand_chance(7)) begin
            thermal_alert_i = 1'b1;
            alert_left      = int'(rand_bits(4));
        end else begin
            thermal_alert_i = 1'b0;
        end
        // a pending request stays on the bus until it is taken
        if (!req_valid_i || m_req_fired) begin
            req_valid_i = rand_chance(4);
            if (req_valid_i) begin
                req_state_i = pick_state();
            end
        end
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        check_value("power_state_o", int'(power_state_o), int'(m_state));
        check_value("req_ready_o", int'(req_ready_o), int'(model_ready()));
        check_value("core_clk_en_o", int'(core_clk_en_o), int'(m_core_en));
        check_value("l2_cache_clk_en_o", int'(l2_cache_clk_en_o), int'(m_l2));
        check_value("l3_cache_clk_en_o", int'(l3_cache_clk_en_o), int'(m_l3));
        check_value("interconnect_clk_en_o", int'(interconnect_clk_en_o), int'(m_ic));
    endtask

    int cycle_cnt = 0;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk_i                   = 1'b0;
        rst_ni                  = 1'b0;
        core_busy_i             = '0;
        cache_access_i          = 1'b0;
        cache_miss_i            = 1'b0;
        thermal_alert_i         = 1'b0;
        req_valid_i             = 1'b0;
        req_state_i             = POWER_ACTIVE;
        cfg_aggressive_gating_i = 1'b0;
        cfg_cache_gating_en_i   = 1'b0;
        cfg_retention_mode_i    = 1'b0;
        lfsr_q                  = 16'd45;
        alert_left              = 0;
        model_reset();

        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            check_outputs();   // clocks run and state is ACTIVE during reset
            @(posedge clk_i);
        end
        #(DRIVE_DELAY);
        rst_ni = 1'b1;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            drive_inputs(cyc);
            @(negedge clk_i);
            check_outputs();
            @(posedge clk_i);
            #(DRIVE_DELAY);
            model_step();
        end

        assert (saw_state[4:0] == 5'h1f) else begin
            $display("the run did not reach every power state");
            $display("CHECKS FAILED");
            $fatal(1, "state coverage");
        end
        assert (saw_blocked) else begin
            $display("no request was ever held back during a thermal event");
            $display("CHECKS FAILED");
            $fatal(1, "back-pressure coverage");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* power_mgmt.f */
power_pkg.sv
power_state_fsm.sv
activity_monitor.sv
clock_gating_control.sv
power_mgmt_top.sv
power_mgmt_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f power_mgmt.f --top-module power_mgmt_tb \
    -o sim_power_mgmt \
    && ./obj_dir/sim_power_mgmt | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation run ok" && exit 0
echo "simulation run failed"
exit 1
